// ==== logic/cpuPkg.sv ====
package cpuPkg;

    // Datapath widths
    localparam int regWidth = 32;
    localparam int addrWidth = 14;   // PC counter field
    localparam int regIndexWidth = 4;   // Index as seen by the decoder
    localparam int bankIndexWidth = 5;  // Index into the full bank

    // Register bank layout
    localparam int bankDepth = 17;
    localparam logic [bankIndexWidth-1:0] lrIndex = 5'd13;
    localparam logic [bankIndexWidth-1:0] userSpIndex = 5'd14;
    localparam logic [bankIndexWidth-1:0] pcIndex = 5'd15;
    localparam logic [bankIndexWidth-1:0] privSpIndex = 5'd16;

    // Reset values
    localparam logic [regWidth-1:0] dataAreaStart = 32'd8192;
    localparam logic [regWidth-1:0] stackTop = '1;
    localparam logic [regWidth-1:0] resetPc = '0;

    // Control codes
    localparam logic [2:0] ctrlNone = 3'd0;
    localparam logic [2:0] ctrlAlu = 3'd1;
    localparam logic [2:0] ctrlResetSp = 3'd2;
    localparam logic [2:0] ctrlLoad = 3'd3;
    localparam logic [2:0] ctrlCall = 3'd4;
    localparam logic [2:0] ctrlCommit = 3'd5;
    localparam logic [2:0] ctrlLoadDirect = 3'd6;

    // ALU codes
    localparam logic [2:0] aluAdd = 3'd0;
    localparam logic [2:0] aluSub = 3'd1;
    localparam logic [2:0] aluAnd = 3'd2;
    localparam logic [2:0] aluOr = 3'd3;
    localparam logic [2:0] aluXor = 3'd4;
    localparam logic [2:0] aluPassB = 3'd5;
    localparam logic [2:0] aluShl = 3'd6;

    // Branch conditions
    localparam logic [1:0] brNever = 2'd0;
    localparam logic [1:0] brAlways = 2'd1;
    localparam logic [1:0] brZero = 2'd2;
    localparam logic [1:0] brNotZero = 2'd3;

    // Stack operations
    localparam logic [1:0] stkHold = 2'd0;
    localparam logic [1:0] stkPush = 2'd1;
    localparam logic [1:0] stkPop = 2'd2;
    localparam logic [1:0] stkUnused = 2'd3;

endpackage

// ==== logic/regBank.sv ====
`timescale 1ns/1ps

module regBank (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                enable,
    input  logic                                privilegedMode,
    input  logic [2:0]                          control,
    input  logic [cpuPkg::regIndexWidth-1:0]    srcA,
    input  logic [cpuPkg::regIndexWidth-1:0]    srcB,
    input  logic [cpuPkg::regIndexWidth-1:0]    dest,
    input  logic [cpuPkg::regWidth-1:0]         aluResult,
    input  logic [cpuPkg::regWidth-1:0]         dataFromMemory,
    input  logic [cpuPkg::regWidth-1:0]         newSp,
    input  logic [cpuPkg::regWidth-1:0]         nextPc,
    input  logic                                shouldBranch,
    output logic [cpuPkg::regWidth-1:0]         readDataA,
    output logic [cpuPkg::regWidth-1:0]         readDataB,
    output logic [cpuPkg::regWidth-1:0]         memoryOutput,
    output logic [cpuPkg::regWidth-1:0]         currentPc,
    output logic [cpuPkg::regWidth-1:0]         currentSp
);

    logic [cpuPkg::regWidth-1:0] bank [cpuPkg::bankDepth];
    logic [cpuPkg::regWidth-1:0] memBuffer;
    logic [cpuPkg::bankIndexWidth-1:0] storedDest;
    logic pendingLoad;

    logic [cpuPkg::bankIndexWidth-1:0] spIndex;
    logic [cpuPkg::bankIndexWidth-1:0] destIndex;
    logic destWritable;

    // Index 14 always maps to the stack pointer of the current mode
    function automatic logic [cpuPkg::bankIndexWidth-1:0] steerIndex(
        input logic [cpuPkg::regIndexWidth-1:0]  sel,
        input logic [cpuPkg::bankIndexWidth-1:0] spSel
    );
        logic [cpuPkg::bankIndexWidth-1:0] wide;
        wide = (cpuPkg::bankIndexWidth)'(sel);
        if (wide == cpuPkg::userSpIndex) begin
            return spSel;
        end
        return wide;
    endfunction

    assign spIndex = privilegedMode ? cpuPkg::privSpIndex : cpuPkg::userSpIndex;
    assign destIndex = (cpuPkg::bankIndexWidth)'(dest);
    assign destWritable = (destIndex != cpuPkg::userSpIndex) && (destIndex != cpuPkg::pcIndex);

    assign readDataA = bank[steerIndex(srcA, spIndex)];
    assign readDataB = bank[steerIndex(srcB, spIndex)];
    assign memoryOutput = bank[steerIndex(dest, spIndex)];
    assign currentPc = bank[cpuPkg::pcIndex];
    assign currentSp = bank[spIndex];

    always_ff @(posedge clock) begin
        memBuffer <= dataFromMemory;   // Free-running, enable does not gate it
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < cpuPkg::bankDepth; i++) begin
                bank[i] <= '0;
            end
            bank[0] <= cpuPkg::dataAreaStart;
            bank[cpuPkg::userSpIndex] <= cpuPkg::stackTop;
            bank[cpuPkg::pcIndex] <= cpuPkg::resetPc;
            bank[cpuPkg::privSpIndex] <= cpuPkg::stackTop;
            pendingLoad <= 1'b0;
        end else if (enable) begin
            bank[cpuPkg::pcIndex] <= shouldBranch ? aluResult : nextPc;
            bank[spIndex] <= (control == cpuPkg::ctrlResetSp) ? cpuPkg::stackTop : newSp;

            case (control)
                cpuPkg::ctrlNone: ;
                cpuPkg::ctrlAlu: begin
                    if (destWritable) begin
                        bank[destIndex] <= aluResult;
                    end
                end
                cpuPkg::ctrlResetSp: begin
                    bank[0] <= cpuPkg::dataAreaStart;   // SP handled above
                end
                cpuPkg::ctrlLoad: begin
                    if (destWritable) begin
                        storedDest <= destIndex;   // Later load replaces earlier one
                        pendingLoad <= 1'b1;
                    end
                end
                cpuPkg::ctrlCall: begin
                    bank[cpuPkg::lrIndex] <= bank[cpuPkg::pcIndex];
                end
                cpuPkg::ctrlCommit: begin
                    if (pendingLoad) begin
                        bank[storedDest] <= memBuffer;
                        pendingLoad <= 1'b0;
                    end
                end
                cpuPkg::ctrlLoadDirect: begin
                    if (destWritable) begin
                        bank[destIndex] <= dataFromMemory;
                    end
                end
                default: ;
            endcase
        end
    end

    // Decoder must not emit the unused control code
    controlInRange: assert property (@(posedge clock) disable iff (reset)
        enable |-> control <= cpuPkg::ctrlLoadDirect);

endmodule

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
    input  logic                        clock,
    input  logic                        reset,
    input  logic [cpuPkg::regWidth-1:0] opA,
    input  logic [cpuPkg::regWidth-1:0] opB,
    input  logic [2:0]                  aluOp,
    output logic [cpuPkg::regWidth-1:0] result,
    output logic                        zero
);

    always_comb begin
        case (aluOp)
            cpuPkg::aluAdd: begin
                result = opA + opB;
            end
            cpuPkg::aluSub: begin
                result = opA - opB;
            end
            cpuPkg::aluAnd: begin
                result = opA & opB;
            end
            cpuPkg::aluOr: begin
                result = opA | opB;
            end
            cpuPkg::aluXor: begin
                result = opA ^ opB;
            end
            cpuPkg::aluPassB: begin
                result = opB;
            end
            cpuPkg::aluShl: begin
                result = opA << opB[4:0];   // Shift amount from low 5 bits
            end
            default: begin
                result = '0;
            end
        endcase
    end

    assign zero = (result == '0);

    // An X opcode would poison the PC through the branch path
    aluOpKnown: assert property (@(posedge clock) disable iff (reset)
        !$isunknown(aluOp));

endmodule

// ==== logic/pcUnit.sv ====
`timescale 1ns/1ps

module pcUnit (
    input  logic [cpuPkg::regWidth-1:0] currentPc,
    input  logic [1:0]                  branchCond,
    input  logic                        zero,
    output logic [cpuPkg::regWidth-1:0] nextPc,
    output logic                        shouldBranch
);

    logic [cpuPkg::addrWidth-1:0] pcField;
    logic [cpuPkg::addrWidth-1:0] pcPlusOne;

    assign pcField = currentPc[cpuPkg::addrWidth-1:0];
    assign pcPlusOne = pcField + (cpuPkg::addrWidth)'(1);   // Wraps within the field
    assign nextPc = (cpuPkg::regWidth)'(pcPlusOne);

    always_comb begin
        case (branchCond)
            cpuPkg::brNever: shouldBranch = 1'b0;
            cpuPkg::brAlways: shouldBranch = 1'b1;
            cpuPkg::brZero: shouldBranch = zero;
            cpuPkg::brNotZero: shouldBranch = !zero;
            default: shouldBranch = 1'b0;
        endcase
    end

endmodule

// ==== logic/stackUnit.sv ====
`timescale 1ns/1ps

module stackUnit (
    input  logic                        clock,
    input  logic                        reset,
    input  logic                        enable,
    input  logic [cpuPkg::regWidth-1:0] currentSp,
    input  logic [1:0]                  stackOp,
    output logic [cpuPkg::regWidth-1:0] newSp
);

    always_comb begin
        case (stackOp)
            cpuPkg::stkPush: newSp = currentSp - (cpuPkg::regWidth)'(1);   // Grows down
            cpuPkg::stkPop: newSp = currentSp + (cpuPkg::regWidth)'(1);
            cpuPkg::stkHold: newSp = currentSp;
            default: newSp = currentSp;
        endcase
    end

    stackOpValid: assert property (@(posedge clock) disable iff (reset)
        enable |-> stackOp != cpuPkg::stkUnused);

endmodule

// ==== logic/cpuCore.sv ====
`timescale 1ns/1ps

module cpuCore (
    input  logic                                clock,
    input  logic                                reset,
    input  logic                                enable,
    input  logic                                privilegedMode,
    input  logic [2:0]                          control,
    input  logic [cpuPkg::regIndexWidth-1:0]    srcA,
    input  logic [cpuPkg::regIndexWidth-1:0]    srcB,
    input  logic [cpuPkg::regIndexWidth-1:0]    dest,
    input  logic [2:0]                          aluOp,
    input  logic                                useImmediate,
    input  logic [cpuPkg::regWidth-1:0]         immediate,
    input  logic [1:0]                          branchCond,
    input  logic [1:0]                          stackOp,
    input  logic [cpuPkg::regWidth-1:0]         dataFromMemory,
    output logic [cpuPkg::regWidth-1:0]         readDataA,
    output logic [cpuPkg::regWidth-1:0]         readDataB,
    output logic [cpuPkg::regWidth-1:0]         currentPc,
    output logic [cpuPkg::regWidth-1:0]         currentSp,
    output logic [cpuPkg::regWidth-1:0]         memoryOutput,
    output logic [cpuPkg::regWidth-1:0]         aluResult   // Memory address and branch target
);

    logic [cpuPkg::regWidth-1:0] operandB;
    logic [cpuPkg::regWidth-1:0] nextPc;
    logic [cpuPkg::regWidth-1:0] newSp;
    logic zero;
    logic shouldBranch;

    assign operandB = useImmediate ? immediate : readDataB;

    regBank bankInst (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .privilegedMode(privilegedMode),
        .control(control),
        .srcA(srcA),
        .srcB(srcB),
        .dest(dest),
        .aluResult(aluResult),
        .dataFromMemory(dataFromMemory),
        .newSp(newSp),
        .nextPc(nextPc),
        .shouldBranch(shouldBranch),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .memoryOutput(memoryOutput),
        .currentPc(currentPc),
        .currentSp(currentSp)
    );

    alu aluInst (
        .clock(clock),
        .reset(reset),
        .opA(readDataA),
        .opB(operandB),
        .aluOp(aluOp),
        .result(aluResult),
        .zero(zero)
    );

    pcUnit pcInst (
        .currentPc(currentPc),
        .branchCond(branchCond),
        .zero(zero),
        .nextPc(nextPc),
        .shouldBranch(shouldBranch)
    );

    stackUnit stackInst (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .currentSp(currentSp),
        .stackOp(stackOp),
        .newSp(newSp)
    );

endmodule

// ==== tb/cpuCoreTb.sv ====
`timescale 1ns/1ps

module cpuCoreTb;

    localparam string stimPath = "tb/cpuCoreStim.txt";
    localparam int periodNs = 20;
    localparam int fieldCount = 17;   // 12 input fields, 5 expected values

    logic clock;
    logic reset;
    logic enable;
    logic privilegedMode;
    logic [2:0] control;
    logic [3:0] srcA;
    logic [3:0] srcB;
    logic [3:0] dest;
    logic [2:0] aluOp;
    logic useImmediate;
    logic [31:0] immediate;
    logic [1:0] branchCond;
    logic [1:0] stackOp;
    logic [31:0] dataFromMemory;
    logic [31:0] readDataA;
    logic [31:0] readDataB;
    logic [31:0] currentPc;
    logic [31:0] currentSp;
    logic [31:0] memoryOutput;
    logic [31:0] aluResult;

    int errors = 0;
    int lineCount = 0;
    bit countDone = 0;

    cpuCore DUT (
        .clock(clock),
        .reset(reset),
        .enable(enable),
        .privilegedMode(privilegedMode),
        .control(control),
        .srcA(srcA),
        .srcB(srcB),
        .dest(dest),
        .aluOp(aluOp),
        .useImmediate(useImmediate),
        .immediate(immediate),
        .branchCond(branchCond),
        .stackOp(stackOp),
        .dataFromMemory(dataFromMemory),
        .readDataA(readDataA),
        .readDataB(readDataB),
        .currentPc(currentPc),
        .currentSp(currentSp),
        .memoryOutput(memoryOutput),
        .aluResult(aluResult)
    );

    always #(periodNs / 2) clock = ~clock;

    function automatic bit isDataLine(input string text);
        return text.len() > 1 && text.getc(0) != 8'h23;   // Hash starts a comment
    endfunction

    task automatic compareOutput(input string name, input logic [31:0] got,
                                 input logic [31:0] want);
        if (got !== want) begin
            $display("CHECK FAILED at %0t: %s expected %h, got %h", $time, name, want, got);
            errors++;
        end
    endtask

    initial begin
        int fd;
        int fields;
        string text;
        logic [31:0] f [fieldCount];
        clock = 1'b0;
        reset = 1'b1;
        enable = 1'b0;
        privilegedMode = 1'b0;
        control = '0;
        srcA = '0;
        srcB = '0;
        dest = '0;
        aluOp = '0;
        useImmediate = 1'b0;
        immediate = '0;
        branchCond = '0;
        stackOp = '0;
        dataFromMemory = '0;

        fd = $fopen(stimPath, "r");
        if (fd == 0) begin
            $display("Stimulus file %s could not be opened", stimPath);
            errors++;
        end else begin
            while ($fgets(text, fd) != 0) begin
                if (isDataLine(text)) begin
                    lineCount++;
                end
            end
            $fclose(fd);
            fd = $fopen(stimPath, "r");   // Second pass drives the DUT
        end
        countDone = 1'b1;

        repeat (3) @(posedge clock);
        reset <= 1'b0;

        while (fd != 0 && $fgets(text, fd) != 0) begin
            if (isDataLine(text)) begin
                fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                    f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                    f[9], f[10], f[11], f[12], f[13], f[14], f[15], f[16]);
                if (fields != fieldCount) begin
                    $display("Stimulus line has %0d fields instead of %0d: %s",
                             fields, fieldCount, text);
                    errors++;
                end else begin
                    @(posedge clock);
                    enable <= f[0][0];
                    privilegedMode <= f[1][0];
                    control <= f[2][2:0];
                    srcA <= f[3][3:0];
                    srcB <= f[4][3:0];
                    dest <= f[5][3:0];
                    aluOp <= f[6][2:0];
                    useImmediate <= f[7][0];
                    immediate <= f[8];
                    branchCond <= f[9][1:0];
                    stackOp <= f[10][1:0];
                    dataFromMemory <= f[11];
                    @(negedge clock);   // Outputs settled mid-cycle
                    compareOutput("readDataA", readDataA, f[12]);
                    compareOutput("currentPc", currentPc, f[13]);
                    compareOutput("currentSp", currentSp, f[14]);
                    compareOutput("memoryOutput", memoryOutput, f[15]);
                    compareOutput("aluResult", aluResult, f[16]);
                    // Register operand B follows from the expected sum or difference
                    if (f[7][0] == 1'b0 && f[6][2:0] == cpuPkg::aluAdd) begin
                        compareOutput("readDataB", readDataB, f[16] - f[12]);
                    end else if (f[7][0] == 1'b0 && f[6][2:0] == cpuPkg::aluSub) begin
                        compareOutput("readDataB", readDataB, f[12] - f[16]);
                    end
                end
            end
        end

        $display("Run complete over %0d stimulus lines with %0d errors", lineCount, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

    // Reset, every stimulus line and some slack
    initial begin
        wait (countDone);
        #((lineCount + 10) * periodNs);
        $display("Watchdog timeout after %0d cycles, stimulus did not finish", lineCount + 10);
        $display("ERRORS FOUND");
        $finish;
    end

endmodule

// ==== tb/cpuCoreStim.txt ====
# en pm ctl srcA srcB dest aluOp useImm immediate br stk dataFromMemory
# then expected readDataA currentPc currentSp memoryOutput aluResult, all hex
0 0 0 0 0 0 0 0 00000000 0 0 00000000 00002000 00000000 ffffffff 00002000 00004000
0 1 0 0 0 0 0 0 00000000 0 0 00000000 00002000 00000000 ffffffff 00002000 00004000
1 0 1 0 0 1 5 1 12345678 0 0 00000000 00002000 00000000 ffffffff 00000000 12345678
1 0 1 1 0 2 0 1 00000008 0 0 00000000 12345678 00000001 ffffffff 00000000 12345680
1 0 1 2 1 3 1 0 00000000 0 0 00000000 12345680 00000002 ffffffff 00000000 00000008
1 0 1 1 0 4 2 1 0000ff00 0 0 00000000 12345678 00000003 ffffffff 00000000 00005600
1 0 1 4 3 5 3 0 00000000 0 0 00000000 00005600 00000004 ffffffff 00000000 00005608
1 0 1 1 0 6 4 1 ffffffff 0 0 00000000 12345678 00000005 ffffffff 00000000 edcba987
1 0 1 3 3 7 6 0 00000000 0 0 00000000 00000008 00000006 ffffffff 00000000 00000800
1 0 1 1 0 8 6 1 00000024 0 0 00000000 12345678 00000007 ffffffff 00000000 23456780
1 0 0 8 0 7 0 0 00000000 0 0 00000000 23456780 00000008 ffffffff 00000800 23458780
1 0 1 0 0 e 5 1 deadbeef 0 0 00000000 00002000 00000009 ffffffff ffffffff deadbeef
1 0 1 0 0 f 5 1 deadbeef 0 0 00000000 00002000 0000000a ffffffff 0000000a deadbeef
1 0 0 e 0 f 0 0 00000000 0 0 00000000 ffffffff 0000000b ffffffff 0000000b 00001fff
0 0 0 0 0 0 0 0 00000000 0 0 00000000 00002000 0000000c ffffffff 00002000 00004000
0 0 0 0 0 0 0 0 00000000 0 0 00000000 00002000 0000000c ffffffff 00002000 00004000
1 0 0 0 0 0 5 1 00000040 1 0 00000000 00002000 0000000c ffffffff 00002000 00000040
1 0 0 0 0 0 5 1 00000080 2 0 00000000 00002000 00000040 ffffffff 00002000 00000080
1 0 0 0 0 0 5 1 00000100 3 0 00000000 00002000 00000041 ffffffff 00002000 00000100
1 0 0 1 1 0 1 0 00000000 3 0 00000000 12345678 00000100 ffffffff 00002000 00000000
1 0 0 1 1 0 1 0 00000000 2 0 00000000 12345678 00000101 ffffffff 00002000 00000000
1 0 0 0 0 0 5 1 00000300 0 0 00000000 00002000 00000000 ffffffff 00002000 00000300
1 0 0 0 0 0 5 1 00003fff 1 0 00000000 00002000 00000001 ffffffff 00002000 00003fff
1 0 0 0 0 0 0 0 00000000 0 0 00000000 00002000 00003fff ffffffff 00002000 00004000
1 0 0 e 0 0 0 0 00000000 0 1 00000000 ffffffff 00000000 ffffffff 00002000 00001fff
1 0 0 e 0 0 0 0 00000000 0 1 00000000 fffffffe 00000001 fffffffe 00002000 00001ffe
1 0 0 e 0 0 0 0 00000000 0 2 00000000 fffffffd 00000002 fffffffd 00002000 00001ffd
1 1 0 e 0 0 0 0 00000000 0 1 00000000 ffffffff 00000003 ffffffff 00002000 00001fff
1 0 0 e 0 0 0 0 00000000 0 0 00000000 fffffffe 00000004 fffffffe 00002000 00001ffe
1 0 1 0 0 0 5 1 00000077 0 0 00000000 00002000 00000005 fffffffe 00002000 00000077
1 0 2 0 0 0 0 0 00000000 0 1 00000000 00000077 00000006 fffffffe 00000077 000000ee
1 1 0 e 0 0 0 0 00000000 0 0 00000000 fffffffe 00000007 fffffffe 00002000 00001ffe
1 0 0 e 0 0 0 0 00000000 0 0 00000000 ffffffff 00000008 ffffffff 00002000 00001fff
1 0 3 9 0 9 0 0 00000000 0 0 aaaa0001 00000000 00000009 ffffffff 00000000 00002000
1 0 0 9 0 9 0 0 00000000 0 0 bbbb0002 00000000 0000000a ffffffff 00000000 00002000
1 0 5 9 0 9 0 0 00000000 0 0 cccc0003 00000000 0000000b ffffffff 00000000 00002000
1 0 0 9 0 9 0 0 00000000 0 0 dddd0004 bbbb0002 0000000c ffffffff bbbb0002 bbbb2002
1 0 5 9 0 9 0 0 00000000 0 0 00000000 bbbb0002 0000000d ffffffff bbbb0002 bbbb2002
1 0 0 9 0 9 0 0 00000000 0 0 00000000 bbbb0002 0000000e ffffffff bbbb0002 bbbb2002
1 0 6 a 0 a 0 0 00000000 0 0 eeee0005 00000000 0000000f ffffffff 00000000 00002000
1 0 0 a 0 a 0 0 00000000 0 0 00000000 eeee0005 00000010 ffffffff eeee0005 eeee2005
1 0 4 d 0 0 0 0 00000000 0 0 00000000 00000000 00000011 ffffffff 00002000 00002000
1 0 0 d 0 d 0 0 00000000 0 0 00000000 00000011 00000012 ffffffff 00000011 00002011

// ==== src.f ====
logic/cpuPkg.sv
logic/regBank.sv
logic/alu.sv
logic/pcUnit.sv
logic/stackUnit.sv
logic/cpuCore.sv
tb/cpuCoreTb.sv

// ==== Makefile ====
SIM := obj_dir/VcpuCoreTb

.PHONY: all run clean

all: run

$(SIM): src.f $(wildcard logic/*.sv) $(wildcard tb/*.sv)
	verilator --binary --timing --assert --top-module cpuCoreTb -f src.f

run: $(SIM)
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx 'NO ERRORS'

clean:
	rm -rf obj_dir
